/* hyperbus_pkg.sv */
// Fixed HyperRAM memory-space encoding only; a command word is sent most significant byte first.
package hyperbus_pkg;

  // Command-address word as the HyperBus device decodes it.
  typedef struct packed {
    logic        rw;
    logic        addr_space;
    logic        burst_type;
    logic [28:0] addr_upper;
    logic [12:0] reserved;
    logic [2:0]  addr_lower;
  } hb_ca_t;

  // Same word seen as six bytes, bytes[5] leaves the PHY first.
  typedef union packed {
    hb_ca_t          fields;
    logic [5:0][7:0] bytes;
  } hb_ca_u;

  // Write word with byte strobes, strb[1] belongs to data[15:8].
  typedef struct packed {
    logic [15:0] data;
    logic [1:0]  strb;
  } hb_tx_word_t;

  typedef enum logic [2:0] {
    IDLE,
    CMD,
    LATENCY,
    DATA,
    DONE
  } hb_state_e;

endpackage

/* hyperbus_cmd_gen.sv */
// Holds one command, so trans_ready_o reopens once the controller takes it; addresses count words.
`timescale 1ns/1ps

module hyperbus_cmd_gen import hyperbus_pkg::*; #(
  parameter int NR_CS       = 2,
  parameter int BURST_WIDTH = 12
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   trans_valid_i,
  output logic                   trans_ready_o,
  input  logic [31:0]            trans_address_i,
  input  logic [NR_CS-1:0]       trans_cs_i,
  input  logic                   trans_write_i,
  input  logic [BURST_WIDTH-1:0] trans_burst_i,
  input  logic                   cmd_take_i,
  output logic                   cmd_valid_o,
  output hb_ca_u                 ca_o,
  output logic [NR_CS-1:0]       cs_o,
  output logic                   write_o,
  output logic [BURST_WIDTH-1:0] burst_o
);

  logic                   cmd_valid_q;
  logic                   accept;
  hb_ca_u                 ca_q;
  logic [NR_CS-1:0]       cs_q;
  logic                   write_q;
  logic [BURST_WIDTH-1:0] burst_q;

  assign trans_ready_o = ~cmd_valid_q;
  assign accept        = trans_valid_i & trans_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_valid_q <= 1'b0;
    end else if (accept) begin
      cmd_valid_q <= 1'b1;
    end else if (cmd_take_i) begin
      cmd_valid_q <= 1'b0;
    end
  end

  // Linear burst in memory space, rw high for a read.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ca_q.fields.rw         <= ~trans_write_i;
      ca_q.fields.addr_space <= 1'b0;
      ca_q.fields.burst_type <= 1'b1;
      ca_q.fields.addr_upper <= trans_address_i[31:3];
      ca_q.fields.reserved   <= '0;
      ca_q.fields.addr_lower <= trans_address_i[2:0];
      cs_q                   <= trans_cs_i;
      write_q                <= trans_write_i;
      burst_q                <= trans_burst_i;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign ca_o        = ca_q;
  assign cs_o        = cs_q;
  assign write_o     = write_q;
  assign burst_o     = burst_q;

endmodule

/* hyperbus_tx_path.sv */
// High byte leaves first; a cleared strobe bit raises RWDS, which the device reads as a byte mask.
`timescale 1ns/1ps

module hyperbus_tx_path import hyperbus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        tx_valid_i,
  output logic        tx_ready_o,
  input  logic [15:0] tx_data_i,
  input  logic [1:0]  tx_strb_i,
  input  logic        byte_take_i,
  output logic        byte_valid_o,
  output logic [7:0]  byte_o,
  output logic        mask_o
);

  hb_tx_word_t word_q;
  logic        full_q;
  logic        low_q;
  logic        load;

  // A new word may enter in the cycle its predecessor's low byte is taken.
  assign tx_ready_o = ~full_q | (low_q & byte_take_i);
  assign load       = tx_valid_i & tx_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      low_q  <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
      low_q  <= 1'b0;
    end else if (byte_take_i) begin
      full_q <= ~low_q;
      low_q  <= ~low_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      word_q <= '{data: tx_data_i, strb: tx_strb_i};
    end
  end

  assign byte_valid_o = full_q;
  assign byte_o       = low_q ? word_q.data[7:0] : word_q.data[15:8];
  assign mask_o       = low_q ? ~word_q.strb[0] : ~word_q.strb[1];

endmodule

/* hyperbus_rx_path.sv */
// RX_DEPTH must be a power of two, at least 2; RWDS must be driven and steady when rd_phase_i rises.
`timescale 1ns/1ps

module hyperbus_rx_path #(
  parameter int RX_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        rd_phase_i,
  input  logic        hyper_rwds_i,
  input  logic [7:0]  hyper_dq_i,
  input  logic        rx_ready_i,
  output logic        rx_space_o,
  output logic        rx_valid_o,
  output logic [15:0] rx_data_o
);

  localparam int PTR_W = $clog2(RX_DEPTH);
  localparam int CNT_W = $clog2(RX_DEPTH + 1);

  logic [15:0]      mem_q [RX_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             rwds_q;
  logic             low_next_q;
  logic [7:0]       high_q;
  logic             rwds_edge;
  logic             push;
  logic             pop;

  // Every RWDS change carries one byte, sampled half a clk_i cycle after it.
  assign rwds_edge = rd_phase_i && (hyper_rwds_i != rwds_q);
  assign push      = rwds_edge && low_next_q;
  assign pop       = rx_valid_o && rx_ready_i;

  assign rx_valid_o = (count_q != '0);
  assign rx_data_o  = mem_q[rd_ptr_q];
  // Two free slots, one for a word still on the bus.
  assign rx_space_o = (count_q < CNT_W'(RX_DEPTH - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rwds_q     <= 1'b0;
      low_next_q <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
    end else begin
      rwds_q <= hyper_rwds_i;
      if (!rd_phase_i) begin
        low_next_q <= 1'b0;
      end else if (rwds_edge) begin
        low_next_q <= ~low_next_q;
      end
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rwds_edge && !low_next_q) begin
      high_q <= hyper_dq_i;
    end
    if (push) begin
      mem_q[wr_ptr_q] <= {high_q, hyper_dq_i};
    end
  end

endmodule

/* hyperbus_phy_ctrl.sv */
// LATENCY_BEATS must be even and bursts at least one word; the bus clock changes on the falling clk_i.
`timescale 1ns/1ps

module hyperbus_phy_ctrl import hyperbus_pkg::*; #(
  parameter int NR_CS         = 2,
  parameter int BURST_WIDTH   = 12,
  parameter int LATENCY_BEATS = 12
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cmd_valid_i,
  input  hb_ca_u                 ca_i,
  input  logic [NR_CS-1:0]       cs_i,
  input  logic                   write_i,
  input  logic [BURST_WIDTH-1:0] burst_i,
  input  logic                   byte_valid_i,
  input  logic [7:0]             byte_i,
  input  logic                   mask_i,
  input  logic                   rx_space_i,
  output logic                   cmd_take_o,
  output logic                   byte_take_o,
  output logic                   rd_phase_o,
  output hb_state_e              state_o,
  output logic [NR_CS-1:0]       hyper_cs_no,
  output logic                   hyper_ck_o,
  output logic                   hyper_ck_no,
  output logic [7:0]             hyper_dq_o,
  output logic                   hyper_dq_oe_o,
  output logic                   hyper_rwds_o,
  output logic                   hyper_rwds_oe_o,
  output logic                   hyper_reset_no
);

  localparam int BEAT_W = $clog2(LATENCY_BEATS > 6 ? LATENCY_BEATS : 6);

  hb_state_e              state_q;
  logic [BEAT_W-1:0]      beat_q;
  logic [BURST_WIDTH-1:0] words_q;
  hb_ca_u                 ca_q;
  logic                   write_q;
  logic [NR_CS-1:0]       cs_nq;
  logic                   ck_q;
  logic                   reset_q;
  logic                   ck_en;
  logic                   wr_data;

  assign wr_data     = (state_q == DATA) && write_q;
  assign rd_phase_o  = (state_q == DATA) && !write_q;
  assign cmd_take_o  = (state_q == IDLE) && cmd_valid_i;
  assign byte_take_o = wr_data && byte_valid_i;

  // One bus clock edge per clk_i cycle; reads may only stall before a high byte.
  always_comb begin
    unique case (state_q)
      CMD, LATENCY: ck_en = 1'b1;
      DATA:         ck_en = write_q ? byte_valid_i : (beat_q[0] || rx_space_i);
      default:      ck_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      beat_q  <= '0;
      words_q <= '0;
      write_q <= 1'b0;
      cs_nq   <= '1;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (cmd_valid_i) begin
            state_q <= CMD;
            beat_q  <= '0;
            words_q <= burst_i;
            write_q <= write_i;
            cs_nq   <= ~cs_i;
          end
        end
        CMD: begin
          if (beat_q == BEAT_W'(5)) begin
            state_q <= LATENCY;
            beat_q  <= '0;
          end else begin
            beat_q <= beat_q + 1'b1;
          end
        end
        LATENCY: begin
          if (beat_q == BEAT_W'(LATENCY_BEATS - 1)) begin
            state_q <= DATA;
            beat_q  <= '0;
          end else begin
            beat_q <= beat_q + 1'b1;
          end
        end
        DATA: begin
          // Bit 0 of beat_q selects the low byte of the current word.
          if (ck_en) begin
            beat_q <= beat_q + 1'b1;
            if (beat_q[0]) begin
              words_q <= words_q - 1'b1;
              if (words_q == BURST_WIDTH'(1)) begin
                state_q <= DONE;
                cs_nq   <= '1;
              end
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_take_o) begin
      ca_q <= ca_i;
    end
  end

  // Center-aligned to the data, which changes on the rising clk_i.
  always_ff @(negedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ck_q <= 1'b0;
    end else if (ck_en) begin
      ck_q <= ~ck_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reset_q <= 1'b0;
    end else begin
      reset_q <= 1'b1;
    end
  end

  assign hyper_dq_o      = (state_q == CMD) ? ca_q.bytes[3'd5 - beat_q[2:0]] : byte_i;
  assign hyper_dq_oe_o   = (state_q == CMD) || wr_data;
  assign hyper_rwds_o    = mask_i;
  assign hyper_rwds_oe_o = wr_data;
  assign hyper_cs_no     = cs_nq;
  assign hyper_ck_o      = ck_q;
  assign hyper_ck_no     = ~ck_q;
  assign hyper_reset_no  = reset_q;
  assign state_o         = state_q;

endmodule

/* hyperbus_phy.sv */
// HyperRAM only, fixed latency and linear bursts; tri-state pads and DDR cells sit outside this PHY.
`timescale 1ns/1ps

module hyperbus_phy import hyperbus_pkg::*; #(
  parameter int NR_CS         = 2,
  parameter int BURST_WIDTH   = 12,
  parameter int LATENCY_BEATS = 12,
  parameter int RX_DEPTH      = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   trans_valid_i,
  output logic                   trans_ready_o,
  input  logic [31:0]            trans_address_i,
  input  logic [NR_CS-1:0]       trans_cs_i,
  input  logic                   trans_write_i,
  input  logic [BURST_WIDTH-1:0] trans_burst_i,
  input  logic                   tx_valid_i,
  output logic                   tx_ready_o,
  input  logic [15:0]            tx_data_i,
  input  logic [1:0]             tx_strb_i,
  output logic                   rx_valid_o,
  input  logic                   rx_ready_i,
  output logic [15:0]            rx_data_o,
  output logic [NR_CS-1:0]       hyper_cs_no,
  output logic                   hyper_ck_o,
  output logic                   hyper_ck_no,
  output logic                   hyper_rwds_o,
  input  logic                   hyper_rwds_i,
  output logic                   hyper_rwds_oe_o,
  input  logic [7:0]             hyper_dq_i,
  output logic [7:0]             hyper_dq_o,
  output logic                   hyper_dq_oe_o,
  output logic                   hyper_reset_no
);

  logic                   cmd_valid;
  logic                   cmd_take;
  hb_ca_u                 cmd_ca;
  logic [NR_CS-1:0]       cmd_cs;
  logic                   cmd_write;
  logic [BURST_WIDTH-1:0] cmd_burst;
  logic                   byte_valid;
  logic                   byte_take;
  logic [7:0]             tx_byte;
  logic                   tx_mask;
  logic                   rd_phase;
  logic                   rx_space;

  hyperbus_cmd_gen #(
    .NR_CS       (NR_CS),
    .BURST_WIDTH (BURST_WIDTH)
  ) i_cmd_gen (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .trans_valid_i   (trans_valid_i),
    .trans_ready_o   (trans_ready_o),
    .trans_address_i (trans_address_i),
    .trans_cs_i      (trans_cs_i),
    .trans_write_i   (trans_write_i),
    .trans_burst_i   (trans_burst_i),
    .cmd_take_i      (cmd_take),
    .cmd_valid_o     (cmd_valid),
    .ca_o            (cmd_ca),
    .cs_o            (cmd_cs),
    .write_o         (cmd_write),
    .burst_o         (cmd_burst)
  );

  hyperbus_tx_path i_tx_path (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tx_valid_i   (tx_valid_i),
    .tx_ready_o   (tx_ready_o),
    .tx_data_i    (tx_data_i),
    .tx_strb_i    (tx_strb_i),
    .byte_take_i  (byte_take),
    .byte_valid_o (byte_valid),
    .byte_o       (tx_byte),
    .mask_o       (tx_mask)
  );

  hyperbus_rx_path #(
    .RX_DEPTH (RX_DEPTH)
  ) i_rx_path (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rd_phase_i   (rd_phase),
    .hyper_rwds_i (hyper_rwds_i),
    .hyper_dq_i   (hyper_dq_i),
    .rx_ready_i   (rx_ready_i),
    .rx_space_o   (rx_space),
    .rx_valid_o   (rx_valid_o),
    .rx_data_o    (rx_data_o)
  );

  // The state output is left open here and watched by the bound protocol checks.
  hyperbus_phy_ctrl #(
    .NR_CS         (NR_CS),
    .BURST_WIDTH   (BURST_WIDTH),
    .LATENCY_BEATS (LATENCY_BEATS)
  ) i_phy_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_valid_i     (cmd_valid),
    .ca_i            (cmd_ca),
    .cs_i            (cmd_cs),
    .write_i         (cmd_write),
    .burst_i         (cmd_burst),
    .byte_valid_i    (byte_valid),
    .byte_i          (tx_byte),
    .mask_i          (tx_mask),
    .rx_space_i      (rx_space),
    .cmd_take_o      (cmd_take),
    .byte_take_o     (byte_take),
    .rd_phase_o      (rd_phase),
    .state_o         (),
    .hyper_cs_no     (hyper_cs_no),
    .hyper_ck_o      (hyper_ck_o),
    .hyper_ck_no     (hyper_ck_no),
    .hyper_dq_o      (hyper_dq_o),
    .hyper_dq_oe_o   (hyper_dq_oe_o),
    .hyper_rwds_o    (hyper_rwds_o),
    .hyper_rwds_oe_o (hyper_rwds_oe_o),
    .hyper_reset_no  (hyper_reset_no)
  );

endmodule

/* hyperbus_phy_props.sv */
// Protocol checks on the bus controller; they hold only while rst_n_i is high.
`timescale 1ns/1ps

module hyperbus_phy_props import hyperbus_pkg::*; #(
  parameter int NR_CS = 2
) (
  input logic             clk_i,
  input logic             rst_n_i,
  input hb_state_e        state_o,
  input hb_ca_u           ca_i,
  input logic [NR_CS-1:0] hyper_cs_no,
  input logic             hyper_dq_oe_o,
  input logic             rd_phase_o
);

  logic in_cmd;
  logic active;
  logic rd_data;

  assign in_cmd  = (state_o == CMD);
  assign active  = (state_o == CMD) || (state_o == LATENCY) || (state_o == DATA);
  // Read data phase as announced by the rw bit of the command word on the bus.
  assign rd_data = (state_o == DATA) && ca_i.fields.rw;

  a_one_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    active |-> $onehot(~hyper_cs_no))
    else $error("chip select not one-hot during a transaction");

  a_no_dq_on_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_data |-> !hyper_dq_oe_o && rd_phase_o)
    else $error("DQ driven or capture idle during read data phase");

  // Six command bytes, one per cycle.
  a_cmd_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(in_cmd) |-> $past(in_cmd, 2) && $past(in_cmd, 3) && $past(in_cmd, 4) &&
      $past(in_cmd, 5) && $past(in_cmd, 6) && !$past(in_cmd, 7))
    else $error("command phase length is not six cycles");

endmodule

bind hyperbus_phy_ctrl hyperbus_phy_props #(.NR_CS(NR_CS)) i_props (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .state_o       (state_o),
  .ca_i          (ca_q),
  .hyper_cs_no   (hyper_cs_no),
  .hyper_dq_oe_o (hyper_dq_oe_o),
  .rd_phase_o    (rd_phase_o)
);

/* tb_hyperram_model.sv */
// Behavioral HyperRAM on one chip select: 1024 words, fixed latency, linear bursts only.
`timescale 1ns/1ps

module tb_hyperram_model import hyperbus_pkg::*; #(
  parameter int LATENCY_BEATS = 12
) (
  input  logic       cs_ni,
  input  logic       ck_i,
  input  logic [7:0] dq_i,
  input  logic       rwds_i,
  output logic [7:0] dq_o,
  output logic       dq_oe_o,
  output logic       rwds_o,
  output logic       rwds_oe_o
);

  logic [15:0] mem [1024];
  hb_ca_u      ca;
  logic        ck_last;
  logic        is_read;
  logic [31:0] base;
  logic [7:0]  high_q;
  logic        high_mask_q;
  logic [9:0]  a;
  int          edges;
  int          d;

  initial begin
    dq_o      = 8'h00;
    dq_oe_o   = 1'b0;
    rwds_o    = 1'b0;
    rwds_oe_o = 1'b0;
    ck_last   = 1'b0;
    edges     = 0;
  end

  // Every bus clock edge moves one byte, both edges alike.
  always @(ck_i or cs_ni) begin
    if (cs_ni !== 1'b0) begin
      edges     = 0;
      dq_oe_o   = 1'b0;
      rwds_oe_o = 1'b0;
    end else if (ck_i !== ck_last) begin
      if (edges < 6) begin
        ca.bytes[3'(5 - edges)] = dq_i;
        if (edges == 5) begin
          is_read = ca.fields.rw;
          base    = {ca.fields.addr_upper, ca.fields.addr_lower};
          if (is_read) begin
            rwds_o    = 1'b0;
            rwds_oe_o = 1'b1;
            dq_o      = 8'h00;
            dq_oe_o   = 1'b1;
          end
        end
      end else if (edges >= 6 + LATENCY_BEATS) begin
        d = edges - 6 - LATENCY_BEATS;
        a = 10'(base + 32'(d / 2));
        if (is_read) begin
          dq_o   = d[0] ? mem[a][7:0] : mem[a][15:8];
          rwds_o = ~rwds_o;
        end else if (!d[0]) begin
          high_q      = dq_i;
          high_mask_q = rwds_i;
        end else begin
          // RWDS high masks the byte.
          if (!high_mask_q) mem[a][15:8] = high_q;
          if (!rwds_i) mem[a][7:0] = dq_i;
        end
      end
      edges = edges + 1;
    end
    ck_last = ck_i;
  end

endmodule

/* tb_checker.sv */
// Compares each accepted rx word with the testbench reference memory, in address order.
`timescale 1ns/1ps

module tb_checker (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        rx_valid_i,
  input logic        rx_ready_i,
  input logic [15:0] rx_data_i
);

  logic [9:0]  ptr;
  logic [15:0] exp;
  int          words;
  int          total_words;
  int          errors;
  int          test_errs;

  initial begin
    ptr         = '0;
    words       = 0;
    total_words = 0;
    errors      = 0;
    test_errs   = 0;
  end

  task automatic expect_from(input logic [31:0] addr);
    ptr   = addr[9:0];
    words = 0;
  endtask

  task automatic report_test(input string name, input int extra_errs);
    int errs;
    errs = test_errs + extra_errs;
    if (errs == 0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errs);
    test_errs = 0;
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i && rx_valid_i && rx_ready_i) begin
      exp = tb_hyperbus_phy.ref_mem[ptr];
      if (rx_data_i !== exp) begin
        $display("FAIL rx_data_o exp=%h got=%h", exp, rx_data_i);
        errors    = errors + 1;
        test_errs = test_errs + 1;
      end
      ptr         = ptr + 10'd1;
      words       = words + 1;
      total_words = total_words + 1;
    end
  end

endmodule

/* tb_hyperbus_phy.sv */
// Uses chip select 0 only; the model covers 1024 words, so addresses wrap there.
`timescale 1ns/1ps

module tb_hyperbus_phy;
  import hyperbus_pkg::*;

  localparam int LAT     = 12;
  localparam int TIMEOUT = 3000;

  logic        clk;
  logic        rst_n;
  logic        trans_valid;
  logic [31:0] trans_address;
  logic [1:0]  trans_cs;
  logic        trans_write;
  logic [11:0] trans_burst;
  logic        tx_valid;
  logic [15:0] tx_data;
  logic [1:0]  tx_strb;
  logic        rx_ready;
  logic        trans_ready;
  logic        tx_ready;
  logic        rx_valid;
  logic [15:0] rx_data;
  logic [1:0]  cs_n;
  logic        ck;
  logic        ck_n;
  logic        reset_n;
  logic        dut_rwds;
  logic        dut_rwds_oe;
  logic        dut_dq_oe;
  logic        ram_dq_oe;
  logic        ram_rwds;
  logic        ram_rwds_oe;
  logic [7:0]  dut_dq;
  logic [7:0]  ram_dq;
  logic [7:0]  dq_bus;
  logic        rwds_bus;
  logic [15:0] ref_mem [1024];
  logic [31:0] lfsr_q;
  logic        bp_mode;
  int          stretch;
  int          top_errs;
  int          cs_rises;
  int          cs_falls;

  // The driving side wins and an idle bus reads as zero.
  assign dq_bus   = dut_dq_oe ? dut_dq : (ram_dq_oe ? ram_dq : 8'h00);
  assign rwds_bus = dut_rwds_oe ? dut_rwds : (ram_rwds_oe ? ram_rwds : 1'b0);

  hyperbus_phy #(.NR_CS(2), .BURST_WIDTH(12), .LATENCY_BEATS(LAT), .RX_DEPTH(4)) dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .trans_valid_i (trans_valid), .trans_ready_o (trans_ready),
    .trans_address_i (trans_address), .trans_cs_i (trans_cs),
    .trans_write_i (trans_write), .trans_burst_i (trans_burst),
    .tx_valid_i (tx_valid), .tx_ready_o (tx_ready), .tx_data_i (tx_data), .tx_strb_i (tx_strb),
    .rx_valid_o (rx_valid), .rx_ready_i (rx_ready), .rx_data_o (rx_data),
    .hyper_cs_no (cs_n), .hyper_ck_o (ck), .hyper_ck_no (ck_n),
    .hyper_rwds_o (dut_rwds), .hyper_rwds_i (rwds_bus), .hyper_rwds_oe_o (dut_rwds_oe),
    .hyper_dq_i (dq_bus), .hyper_dq_o (dut_dq), .hyper_dq_oe_o (dut_dq_oe),
    .hyper_reset_no (reset_n)
  );

  tb_hyperram_model #(.LATENCY_BEATS(LAT)) hram (
    .cs_ni (cs_n[0]), .ck_i (ck), .dq_i (dq_bus), .rwds_i (rwds_bus),
    .dq_o (ram_dq), .dq_oe_o (ram_dq_oe), .rwds_o (ram_rwds), .rwds_oe_o (ram_rwds_oe)
  );

  tb_checker chk (
    .clk_i (clk), .rst_n_i (rst_n), .rx_valid_i (rx_valid),
    .rx_ready_i (rx_ready), .rx_data_i (rx_data)
  );

  always #4 clk = ~clk;

  always @(posedge cs_n[0]) cs_rises = cs_rises + 1;
  always @(negedge cs_n[0]) cs_falls = cs_falls + 1;

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // Only strobed bytes take the new data.
  function automatic logic [15:0] ref_write_word(input logic [15:0] old,
                                                 input logic [15:0] data, input logic [1:0] strb);
    return {strb[1] ? data[15:8] : old[15:8], strb[0] ? data[7:0] : old[7:0]};
  endfunction

  function automatic logic [15:0] fill_word(input int a);
    return 16'(a * 40503) ^ 16'h5a3c;
  endfunction

  // Long random stalls while bp_mode is set.
  always @(posedge clk) begin
    #1;
    if (!bp_mode) begin
      rx_ready = 1'b1;
    end else if (stretch > 0) begin
      stretch = stretch - 1;
    end else begin
      rx_ready = ~rx_ready;
      stretch  = rx_ready ? int'(rand_bits(2)) : int'(rand_bits(4)) + 4;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("FAIL %s exp=%h got=%h", name, exp, got);
      top_errs = top_errs + 1;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    top_errs = top_errs + 1;
  endtask

  task automatic wait_cs(input logic level);
    int t;
    t = 0;
    while (cs_n[0] !== level && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (cs_n[0] !== level) note_timeout("chip select change");
  endtask

  task automatic start_trans(input logic [31:0] addr, input logic wr, input int words);
    int t;
    trans_address = addr;
    trans_cs      = 2'b01;
    trans_write   = wr;
    trans_burst   = 12'(words);
    trans_valid   = 1'b1;
    t = 0;
    while (!trans_ready && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (!trans_ready) note_timeout("transaction accept");
    @(posedge clk);
    #1;
    trans_valid = 1'b0;
  endtask

  task automatic send_word(input logic [15:0] d, input logic [1:0] s);
    int t;
    tx_valid = 1'b1;
    tx_data  = d;
    tx_strb  = s;
    t = 0;
    while (!tx_ready && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (!tx_ready) note_timeout("tx_ready_o");
    @(posedge clk);
    #1;
    tx_valid = 1'b0;
  endtask

  task automatic write_burst(input logic [31:0] addr, input int n, input logic rnd_strb,
                             input logic gaps);
    logic [15:0] d;
    logic [1:0]  s;
    logic [9:0]  a;
    start_trans(addr, 1'b1, n);
    for (int i = 0; i < n; i++) begin
      d = 16'(rand_bits(16));
      s = rnd_strb ? 2'(rand_bits(2)) : 2'b11;
      if (gaps) begin
        repeat (int'(rand_bits(2))) @(posedge clk);
        #1;
      end
      send_word(d, s);
      a = 10'(addr + 32'(i));
      ref_mem[a] = ref_write_word(ref_mem[a], d, s);
    end
    wait_cs(1'b1);
  endtask

  task automatic read_check(input logic [31:0] addr, input int n, input logic bp);
    int t;
    chk.expect_from(addr);
    bp_mode = bp;
    start_trans(addr, 1'b0, n);
    t = 0;
    while (chk.words < n && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (chk.words < n) note_timeout("read words");
    bp_mode = 1'b0;
    wait_cs(1'b1);
    repeat (4) @(posedge clk);
    #1;
    if (chk.words != n || rx_valid) begin
      $display("Read returned %0d words where %0d were expected", chk.words, n);
      top_errs = top_errs + 1;
    end
  endtask

  initial begin
    int errs_before;
    int rises_before;
    int falls_before;
    clk           = 1'b0;
    rst_n         = 1'b0;
    trans_valid   = 1'b0;
    trans_address = '0;
    trans_cs      = '0;
    trans_write   = 1'b0;
    trans_burst   = '0;
    tx_valid      = 1'b0;
    tx_data       = '0;
    tx_strb       = '0;
    rx_ready      = 1'b0;
    bp_mode       = 1'b0;
    stretch       = 0;
    top_errs      = 0;
    cs_rises      = 0;
    cs_falls      = 0;
    lfsr_q        = 32'h9c50_0b61;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i]  = fill_word(i);
      hram.mem[i] = fill_word(i);
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    errs_before = top_errs;
    check_value("hyper_cs_no", 32'h3, 32'(cs_n));
    check_value("hyper_ck_o", 32'h0, 32'(ck));
    check_value("hyper_ck_no", 32'h1, 32'(ck_n));
    check_value("hyper_dq_oe_o", 32'h0, 32'(dut_dq_oe));
    check_value("hyper_rwds_oe_o", 32'h0, 32'(dut_rwds_oe));
    check_value("trans_ready_o", 32'h1, 32'(trans_ready));
    check_value("tx_ready_o", 32'h1, 32'(tx_ready));
    check_value("rx_valid_o", 32'h0, 32'(rx_valid));
    check_value("hyper_reset_no", 32'h1, 32'(reset_n));
    chk.report_test("reset_state", top_errs - errs_before);

    errs_before = top_errs;
    write_burst(32'd16, 8, 1'b0, 1'b0);
    read_check(32'd16, 8, 1'b0);
    chk.report_test("write_read", top_errs - errs_before);

    errs_before = top_errs;
    write_burst(32'd64, 8, 1'b1, 1'b0);
    read_check(32'd64, 8, 1'b0);
    chk.report_test("byte_mask", top_errs - errs_before);

    errs_before  = top_errs;
    rises_before = cs_rises;
    falls_before = cs_falls;
    write_burst(32'd128, 12, 1'b1, 1'b1);
    if (cs_rises - rises_before != 1 || cs_falls - falls_before != 1) begin
      $display("Chip select went high in the middle of the write burst");
      top_errs = top_errs + 1;
    end
    read_check(32'd128, 12, 1'b0);
    chk.report_test("write_underflow", top_errs - errs_before);

    errs_before = top_errs;
    read_check(32'd60, 16, 1'b1);
    chk.report_test("read_backpressure", top_errs - errs_before);

    $display("tests=5 words=%0d errors=%0d", chk.total_words, chk.errors + top_errs);
    if (chk.errors + top_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* flist.f */
hyperbus_pkg.sv
hyperbus_cmd_gen.sv
hyperbus_tx_path.sv
hyperbus_rx_path.sv
hyperbus_phy_ctrl.sv
hyperbus_phy.sv
hyperbus_phy_props.sv
tb_hyperram_model.sv
tb_checker.sv
tb_hyperbus_phy.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_hyperbus_phy -f flist.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "All checks passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi
